//--- hw/positDecode.sv
`timescale 1ns/1ns
////////////////////
// Posit decode stage
// Classifies the operand, strips the regime and registers
// sign, scale, fraction and opcode
////////////////////
module positDecode (
  input  logic               clock,
  input  logic               resetn,
  input  logic               ivalid,
  input  positPkg::posit_t   positA,
  input  positPkg::positOp_e op,
  output logic               decValid,
  output positPkg::decoded_t dec
);
  import positPkg::*;

  posit_t                       absA;
  logic [posWidth-2:0]          body;
  logic [posWidth-2:0]          runBits;
  logic [posWidth-2:0]          tail;
  logic                         regimeSign;
  logic [2:0]                   runLen;
  logic signed [scaleWidth-1:0] regimeK;
  decoded_t                     decNext;

  always_comb begin
    absA = positA[posWidth-1] ? posit_t'(-positA) : positA;
    body = absA[posWidth-2:0];
    regimeSign = body[posWidth-2];
    runBits = regimeSign ? ~body : body;  // Regime run turns into leading zeros

    // Leading zero count, highest set bit wins
    runLen = 3'd7;
    for (int i = 0; i < posWidth - 1; i++) begin
      if (runBits[i]) begin
        runLen = 3'(posWidth - 2 - i);
      end
    end

    // Drop the run and its terminator, exponent lands on top
    tail = body << (4'(runLen) + 4'd1);

    if (regimeSign) begin
      regimeK = $signed({2'b00, runLen}) - 5'sd1;
    end else begin
      regimeK = -$signed({2'b00, runLen});
    end

    decNext.sign = positA[posWidth-1];
    decNext.scale = (regimeK <<< posEs) + $signed({1'b0, tail[posWidth-2]});
    decNext.frac = tail[posWidth-3 -: fracWidth];
    decNext.op = op;

    if (positA == '0) begin
      decNext.cls = clsZero;
    end else if (positA == posNaR) begin
      decNext.cls = clsNaR;
    end else begin
      decNext.cls = clsNormal;
    end
  end

  always_ff @(posedge clock) begin
    if (!resetn) begin
      decValid <= 1'b0;
    end else begin
      decValid <= ivalid;
    end
  end

  always_ff @(posedge clock) begin
    if (ivalid) begin
      dec <= decNext;
    end
  end

  // A valid decoded word must be fully known for the table and encoder
  decKnown: assert property (@(posedge clock) disable iff (!resetn)
    decValid |-> !$isunknown(dec))
    else $error("decoded operand has unknown bits while decValid is high");

endmodule

//--- hw/positFracTable.sv
`timescale 1ns/1ns
////////////////////
// Posit function tables
// Reciprocal and square root mantissas with result scale
////////////////////
module positFracTable (
  input  positPkg::decoded_t dec,
  output positPkg::mant_t    mant,
  output logic signed [5:0]  resScale
);
  import positPkg::*;

  mant_t                      invMant;
  mant_t                      sqrtMant;
  logic signed [scaleWidth:0] scaleExt;

  // 2/(1+f/16) - 1, nine bits truncated
  always_comb begin
    invMant = '0;
    case (dec.frac)
      4'd0:  invMant = '{9'd0,   1'b0};  // Exact power of two
      4'd1:  invMant = '{9'd451, 1'b1};
      4'd2:  invMant = '{9'd398, 1'b1};
      4'd3:  invMant = '{9'd350, 1'b1};
      4'd4:  invMant = '{9'd307, 1'b1};
      4'd5:  invMant = '{9'd268, 1'b1};
      4'd6:  invMant = '{9'd232, 1'b1};
      4'd7:  invMant = '{9'd200, 1'b1};
      4'd8:  invMant = '{9'd170, 1'b1};
      4'd9:  invMant = '{9'd143, 1'b1};
      4'd10: invMant = '{9'd118, 1'b1};
      4'd11: invMant = '{9'd94,  1'b1};
      4'd12: invMant = '{9'd73,  1'b1};
      4'd13: invMant = '{9'd52,  1'b1};
      4'd14: invMant = '{9'd34,  1'b1};
      4'd15: invMant = '{9'd16,  1'b1};
    endcase
  end

  // sqrt(p*(1+f/16)) - 1 with p = 2 for odd scale
  always_comb begin
    sqrtMant = '0;
    case ({dec.scale[0], dec.frac})
      5'd0:  sqrtMant = '{9'd0,   1'b0};
      5'd1:  sqrtMant = '{9'd15,  1'b1};
      5'd2:  sqrtMant = '{9'd31,  1'b1};
      5'd3:  sqrtMant = '{9'd45,  1'b1};
      5'd4:  sqrtMant = '{9'd60,  1'b1};
      5'd5:  sqrtMant = '{9'd74,  1'b1};
      5'd6:  sqrtMant = '{9'd88,  1'b1};
      5'd7:  sqrtMant = '{9'd101, 1'b1};
      5'd8:  sqrtMant = '{9'd115, 1'b1};
      5'd9:  sqrtMant = '{9'd128, 1'b0};  // sqrt(25/16)
      5'd10: sqrtMant = '{9'd140, 1'b1};
      5'd11: sqrtMant = '{9'd153, 1'b1};
      5'd12: sqrtMant = '{9'd165, 1'b1};
      5'd13: sqrtMant = '{9'd177, 1'b1};
      5'd14: sqrtMant = '{9'd189, 1'b1};
      5'd15: sqrtMant = '{9'd200, 1'b1};
      5'd16: sqrtMant = '{9'd212, 1'b1};
      5'd17: sqrtMant = '{9'd234, 1'b1};
      5'd18: sqrtMant = '{9'd256, 1'b0};  // sqrt(36/16)
      5'd19: sqrtMant = '{9'd277, 1'b1};
      5'd20: sqrtMant = '{9'd297, 1'b1};
      5'd21: sqrtMant = '{9'd317, 1'b1};
      5'd22: sqrtMant = '{9'd337, 1'b1};
      5'd23: sqrtMant = '{9'd356, 1'b1};
      5'd24: sqrtMant = '{9'd374, 1'b1};
      5'd25: sqrtMant = '{9'd393, 1'b1};
      5'd26: sqrtMant = '{9'd411, 1'b1};
      5'd27: sqrtMant = '{9'd428, 1'b1};
      5'd28: sqrtMant = '{9'd445, 1'b1};
      5'd29: sqrtMant = '{9'd462, 1'b1};
      5'd30: sqrtMant = '{9'd479, 1'b1};
      5'd31: sqrtMant = '{9'd495, 1'b1};
    endcase
  end

  always_comb begin
    scaleExt = {dec.scale[scaleWidth-1], dec.scale};
    if (dec.op == opInv) begin
      mant = invMant;
      if (dec.frac == '0) begin
        resScale = -scaleExt;
      end else begin
        resScale = -scaleExt - 6'sd1;   // Quotient below one, renormalized
      end
    end else begin
      mant = sqrtMant;
      resScale = scaleExt >>> 1;        // Floor of scale/2
    end
  end

endmodule

//--- hw/positPkg.sv
////////////////////
// Posit unary unit definitions
// Format constants, opcodes and pipeline stage structs
// for 8-bit posits with one exponent bit
////////////////////
package positPkg;

  localparam int posWidth = 8;
  localparam int posEs = 1;
  localparam int fracWidth = 4;          // Widest fraction field of an 8-bit posit
  localparam int mantWidth = 9;          // Table fraction bits below the hidden one
  localparam int scaleWidth = 5;         // Holds -12..12

  localparam logic [posWidth-1:0] posNaR = 8'h80;
  localparam int posMaxScale = 12;       // Scale of maxpos
  localparam int posMinScale = -12;      // Scale of minpos

  typedef logic [posWidth-1:0] posit_t;

  typedef enum logic {
    opInv  = 1'b0,                       // Reciprocal
    opSqrt = 1'b1                        // Square root
  } positOp_e;

  typedef enum logic [1:0] {
    clsZero   = 2'd0,
    clsNaR    = 2'd1,
    clsNormal = 2'd2
  } posClass_e;

  // Operand after regime and exponent extraction
  typedef struct packed {
    posClass_e                    cls;
    logic                         sign;
    logic signed [scaleWidth-1:0] scale;  // Regime times 2 plus exponent
    logic [fracWidth-1:0]         frac;   // Left aligned
    positOp_e                     op;
  } decoded_t;

  // Normalized mantissa from the function tables
  typedef struct packed {
    logic [mantWidth-1:0] frac;
    logic                 sticky;         // Set when the true value lies above frac
  } mant_t;

endpackage

//--- hw/positRoundEncode.sv
`timescale 1ns/1ns
////////////////////
// Posit encode stage
// Builds regime, exponent and fraction, rounds to nearest even
// and registers the result
////////////////////
module positRoundEncode (
  input  logic               clock,
  input  logic               resetn,
  input  logic               decValid,
  input  positPkg::decoded_t dec,
  input  positPkg::mant_t    mant,
  input  logic signed [5:0]  resScale,
  output logic               ovalid,
  output positPkg::posit_t   positOut
);
  import positPkg::*;

  localparam int strWidth = 20;         // Regime seed, exponent, mantissa and padding

  logic signed [scaleWidth-1:0] clampScale;
  logic signed [scaleWidth-1:0] regimeK;
  logic                         regimeFirst;
  logic [2:0]                   shiftAmt;
  logic signed [strWidth-1:0]   seed;
  logic [strWidth-1:0]          strBits;
  logic [posWidth-2:0]          cut;
  logic                         guardBit;
  logic                         stickyBit;
  logic                         roundUp;
  logic [posWidth-2:0]          mag;
  posit_t                       result;

  always_comb begin
    if (resScale > posMaxScale) begin
      clampScale = scaleWidth'(posMaxScale);
    end else if (resScale < posMinScale) begin
      clampScale = scaleWidth'(posMinScale);
    end else begin
      clampScale = resScale[scaleWidth-1:0];
    end

    regimeK = clampScale >>> posEs;
    regimeFirst = ~regimeK[scaleWidth-1];   // Ones for k >= 0, zeros below
    shiftAmt = regimeK[scaleWidth-1] ? ~regimeK[2:0] : regimeK[2:0];

    // Two-bit run seed, widened by arithmetic shift
    seed = {regimeFirst, ~regimeFirst, clampScale[0], mant.frac, 8'b0};
    strBits = seed >>> shiftAmt;

    cut = strBits[strWidth-1 -: posWidth-1];
    guardBit = strBits[strWidth-posWidth];
    stickyBit = (|strBits[strWidth-posWidth-1:0]) | mant.sticky;
    roundUp = guardBit & (stickyBit | cut[0]);

    if (roundUp && cut != '1) begin
      mag = cut + 1'b1;
    end else begin
      mag = cut;                        // Stays at maxpos
    end
  end

  always_comb begin
    result = {1'b0, mag};
    if (dec.cls == clsNaR) begin
      result = posNaR;
    end else if (dec.cls == clsZero) begin
      result = (dec.op == opInv) ? posNaR : '0;
    end else if (dec.op == opSqrt && dec.sign) begin
      result = posNaR;
    end else if (dec.sign) begin
      result = -{1'b0, mag};            // Negative reciprocal
    end
  end

  always_ff @(posedge clock) begin
    if (!resetn) begin
      ovalid <= 1'b0;
      positOut <= '0;
    end else begin
      ovalid <= decValid;
      if (decValid) begin
        positOut <= result;
      end
    end
  end

  // A normal operand always lands between minpos and maxpos
  magNonzero: assert property (@(posedge clock) disable iff (!resetn)
    decValid && dec.cls == clsNormal |-> mag != '0)
    else $error("normal operand rounded to zero or NaR");

endmodule

//--- hw/positUnaryUnit.sv
`timescale 1ns/1ns
////////////////////
// Posit unary unit
// Two-stage reciprocal and square root for 8-bit posits
////////////////////
module positUnaryUnit (
  input  logic               clock,
  input  logic               resetn,
  input  logic               ivalid,
  input  positPkg::posit_t   positA,
  input  positPkg::positOp_e op,
  output logic               ovalid,
  output positPkg::posit_t   positOut
);
  import positPkg::*;

  decoded_t          dec;
  logic              decValid;
  mant_t             mant;
  logic signed [5:0] resScale;

  // Stage 1
  positDecode decodeStage (
    .clock    (clock),
    .resetn   (resetn),
    .ivalid   (ivalid),
    .positA   (positA),
    .op       (op),
    .decValid (decValid),
    .dec      (dec)
  );

  positFracTable fracTable (
    .dec      (dec),
    .mant     (mant),
    .resScale (resScale)
  );

  // Stage 2
  positRoundEncode encodeStage (
    .clock    (clock),
    .resetn   (resetn),
    .decValid (decValid),
    .dec      (dec),
    .mant     (mant),
    .resScale (resScale),
    .ovalid   (ovalid),
    .positOut (positOut)
  );

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the posit unary unit testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbUnary -o simUnary \
  && ./obj_dir/simUnary > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

//--- tb.f
hw/positPkg.sv
hw/positDecode.sv
hw/positFracTable.sv
hw/positRoundEncode.sv
hw/positUnaryUnit.sv
verif/unaryChecker.sv
verif/tbUnary.sv

//--- verif/tbUnary.sv
`timescale 1ns/1ns
////////////////////
// Posit unary unit testbench
// Directed, exhaustive and random operands with a
// watchdog and a closing summary
////////////////////
module tbUnary;
  import positPkg::*;

  localparam int specialCount = 10;
  localparam int randomCount = 200;
  localparam int resetDriveCount = 6;
  localparam int latencyCount = 8;
  localparam int totalOperands = specialCount + 512 + randomCount + resetDriveCount
                                 + latencyCount;
  localparam int cycleLimit = 16 + totalOperands * 3 + 50;

  logic        clock;
  logic        resetn;
  logic        ivalid;
  posit_t      positA;
  positOp_e    op;
  logic        ovalid;
  posit_t      positOut;
  int          errors;
  int          checks;
  int          pending;
  int          cycles;
  int          testsRun;
  int          testsBad;
  int          errorsBefore;
  int          checksBefore;
  logic [31:0] lfsrState;

  positUnaryUnit u_dut (
    .clock    (clock),
    .resetn   (resetn),
    .ivalid   (ivalid),
    .positA   (positA),
    .op       (op),
    .ovalid   (ovalid),
    .positOut (positOut)
  );

  unaryChecker resultCheck (
    .clock    (clock),
    .resetn   (resetn),
    .ivalid   (ivalid),
    .positA   (positA),
    .op       (op),
    .ovalid   (ovalid),
    .positOut (positOut),
    .errors   (errors),
    .checks   (checks),
    .pending  (pending)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] randomBits(int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[6:0], lfsrState[0]};
    end
    return r;
  endfunction

  task automatic driveOp(posit_t a, positOp_e o);
    @(posedge clock);
    #1;
    ivalid = 1'b1;
    positA = a;
    op = o;
  endtask

  task automatic idleCycle();
    @(posedge clock);
    #1;
    ivalid = 1'b0;
  endtask

  // Drain the pipeline, then report the test
  task automatic finishTest(string name);
    int newErrors;
    idleCycle();
    while (pending != 0) begin
      idleCycle();
    end
    idleCycle();
    idleCycle();
    newErrors = errors - errorsBefore;
    testsRun++;
    if (newErrors != 0) begin
      testsBad++;
    end
    $display("%s: %0d results checked, %0d errors", name, checks - checksBefore, newErrors);
    errorsBefore = errors;
    checksBefore = checks;
  endtask

  initial begin
    logic [7:0] pickA;
    logic [7:0] pickOp;
    clock = 1'b0;
    resetn = 1'b0;
    ivalid = 1'b0;
    positA = '0;
    op = opInv;
    cycles = 0;
    testsRun = 0;
    testsBad = 0;
    errorsBefore = 0;
    checksBefore = 0;
    lfsrState = 32'h561ec9ee;
    repeat (16) @(posedge clock);
    #1;
    resetn = 1'b1;

    driveOp(8'h00, opInv);
    driveOp(8'h00, opSqrt);
    driveOp(8'h80, opInv);
    driveOp(8'h80, opSqrt);
    driveOp(8'hc0, opSqrt);               // -1
    driveOp(8'h7f, opInv);                // maxpos
    driveOp(8'h01, opInv);                // minpos
    driveOp(8'h81, opInv);
    driveOp(8'h40, opSqrt);
    driveOp(8'h40, opInv);
    finishTest("special values");

    for (int i = 0; i < 256; i++) begin
      driveOp(posit_t'(i), opInv);
    end
    finishTest("exhaustive reciprocal");

    for (int i = 0; i < 256; i++) begin
      driveOp(posit_t'(i), opSqrt);
    end
    finishTest("exhaustive square root");

    for (int i = 0; i < randomCount; i++) begin
      pickA = randomBits(8);
      pickOp = randomBits(1);
      driveOp(pickA, positOp_e'(pickOp[0]));
      if (randomBits(1) == 8'd1) begin
        idleCycle();
      end
    end
    finishTest("random mix");

    // Operands offered while reset is held must vanish
    resetn = 1'b0;
    for (int i = 0; i < resetDriveCount; i++) begin
      driveOp(randomBits(8), opSqrt);
    end
    idleCycle();
    resetn = 1'b1;
    for (int i = 0; i < latencyCount; i++) begin
      driveOp(randomBits(8), opInv);
      idleCycle();
      idleCycle();
    end
    finishTest("reset and latency");

    $display("tests run: %0d, tests with errors: %0d, results checked: %0d, errors: %0d",
             testsRun, testsBad, checks, errors);
    if (errors == 0 && testsBad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verif/unaryChecker.sv
`timescale 1ns/1ns
////////////////////
// Unary unit checker
// Real-valued posit model, expected queue and
// latency checks on the DUT ports
////////////////////
module unaryChecker (
  input  logic               clock,
  input  logic               resetn,
  input  logic               ivalid,
  input  positPkg::posit_t   positA,
  input  positPkg::positOp_e op,
  input  logic               ovalid,
  input  positPkg::posit_t   positOut,
  output int                 errors,
  output int                 checks,
  output int                 pending
);
  import positPkg::*;

  localparam posit_t narPattern = 8'h80;
  localparam int topScale = 12;          // maxpos is 2^12
  localparam int bottomScale = -12;

  posit_t     expQ[$];
  posit_t     argQ[$];
  positOp_e   opQ[$];
  logic [1:0] acceptHist;                // Operands taken at the last two edges
  logic       resetnPrev;
  int         edgeCount;

  function automatic real pow2(int s);
    real v;
    v = 1.0;
    for (int i = 0; i < s; i++) begin
      v = v * 2.0;
    end
    for (int i = 0; i > s; i--) begin
      v = v / 2.0;
    end
    return v;
  endfunction

  // Magnitude of a nonzero, non-NaR posit
  function automatic real positValue(posit_t p);
    posit_t absP;
    logic   r;
    int     i;
    int     run;
    int     k;
    int     e;
    int     frac;
    int     nf;
    absP = p[7] ? posit_t'(-p) : p;
    r = absP[6];
    i = 6;
    run = 0;
    while (i >= 0 && absP[i] == r) begin
      run++;
      i--;
    end
    i--;                                 // Regime terminator
    k = r ? run - 1 : -run;
    e = 0;
    if (i >= 0) begin
      e = int'(absP[i]);
      i--;
    end
    frac = 0;
    nf = 0;
    while (i >= 0) begin
      frac = frac * 2 + int'(absP[i]);
      nf++;
      i--;
    end
    return (1.0 + real'(frac) / pow2(nf)) * pow2(2 * k + e);
  endfunction

  // Nearest posit to a positive real, ties to even on the bit string
  function automatic posit_t roundPositive(real y);
    int          scale;
    int          k;
    int          n;
    real         f;
    logic [63:0] str;
    logic [6:0]  cut;
    logic        guard;
    logic        sticky;
    scale = 0;
    while (y >= 2.0) begin
      y = y / 2.0;
      scale++;
    end
    while (y < 1.0) begin
      y = y * 2.0;
      scale--;
    end
    if (scale > topScale) begin
      return 8'h7f;
    end
    if (scale < bottomScale) begin
      return 8'h01;
    end
    k = scale >>> 1;
    str = '0;
    n = 0;
    for (int j = 0; j < ((k >= 0) ? k + 1 : -k); j++) begin
      str = {str[62:0], k >= 0};
      n++;
    end
    str = {str[62:0], k < 0};            // Run terminator
    str = {str[62:0], 1'(scale - 2 * k)};
    n = n + 2;
    f = y - 1.0;
    for (int j = 0; j < 24; j++) begin
      f = f * 2.0;
      str = {str[62:0], f >= 1.0};
      if (f >= 1.0) begin
        f = f - 1.0;
      end
      n++;
    end
    str = {str[62:0], f != 0.0};
    n++;
    cut = 7'(str >> (n - 7));
    guard = str[n - 8];
    sticky = |(str & ((64'd1 << (n - 8)) - 64'd1));
    if (guard && (sticky || cut[0]) && cut != 7'h7f) begin
      cut = cut + 7'd1;
    end
    return {1'b0, cut};
  endfunction

  function automatic posit_t expectedResult(posit_t a, positOp_e o);
    posit_t mag;
    if (a == narPattern) begin
      return narPattern;
    end
    if (a == 8'h00) begin
      return (o == opInv) ? narPattern : 8'h00;
    end
    if (o == opSqrt) begin
      return a[7] ? narPattern : roundPositive($sqrt(positValue(a)));
    end
    mag = roundPositive(1.0 / positValue(a));
    return a[7] ? posit_t'(-mag) : mag;
  endfunction

  initial begin
    errors = 0;
    checks = 0;
    pending = 0;
    acceptHist = 2'b00;
    resetnPrev = 1'b0;
    edgeCount = 0;
  end

  always @(posedge clock) begin : watch
    logic     expOvalid;
    posit_t   expValue;
    posit_t   argValue;
    positOp_e argOp;
    expOvalid = resetnPrev && acceptHist[1];
    if (edgeCount > 0) begin
      if (ovalid !== expOvalid) begin
        errors++;
        $display("CHECK FAILED at %0t: ovalid is %b, expected %b", $time, ovalid, expOvalid);
      end
      if (!resetnPrev && positOut !== 8'h00) begin
        errors++;
        $display("CHECK FAILED at %0t: positOut is %h after reset, expected 00",
                 $time, positOut);
      end
      if (ovalid === 1'b1) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("At %0t a result came out with no operand waiting for it", $time);
        end else begin
          expValue = expQ.pop_front();
          argValue = argQ.pop_front();
          argOp = opQ.pop_front();
          checks++;
          if (positOut !== expValue) begin
            errors++;
            $display("CHECK FAILED at %0t: %s of %h expected %h got %h",
                     $time, argOp.name(), argValue, expValue, positOut);
          end
        end
      end
    end
    if (resetn && ivalid) begin
      expQ.push_back(expectedResult(positA, op));
      argQ.push_back(positA);
      opQ.push_back(op);
    end
    acceptHist = {acceptHist[0], resetn && ivalid};
    resetnPrev = resetn;
    edgeCount++;
    pending = expQ.size();
  end

endmodule
